// ==== verilog/fbmem_pkg.sv ====
package fbmem_pkg;

    ////////////////////////////////////////
    // Widths and sizing
    ////////////////////////////////////////
    localparam int PIX_BITS      = 16;  // One pixel word
    localparam int ADDR_BITS     = 24;  // Burst address
    localparam int BURST_LEN     = 4;   // Pixels per burst

    localparam int WR_FIFO_DEPTH = 4;   // Posted bursts per write port
    localparam int MEM_ADDR_BITS = 8;   // Low address bits decoded by the memory
    localparam int MEM_LATENCY   = 3;   // Accept to done, in cycles
    localparam int MEM_DEPTH     = 2 ** MEM_ADDR_BITS;

    localparam int FIFO_PTR_BITS = (WR_FIFO_DEPTH > 1) ? $clog2(WR_FIFO_DEPTH) : 1;
    localparam int FIFO_CNT_BITS = $clog2(WR_FIFO_DEPTH + 1);  // Must hold DEPTH itself
    localparam int LAT_CNT_BITS  = $clog2(MEM_LATENCY + 1);

    typedef logic [PIX_BITS-1:0]      pix_t;
    typedef logic [ADDR_BITS-1:0]     baddr_t;
    typedef pix_t [BURST_LEN-1:0]     burst_t;     // Word 0 in bits 15:0
    typedef logic [MEM_ADDR_BITS-1:0] mem_idx_t;
    typedef logic [FIFO_PTR_BITS-1:0] fifo_ptr_t;
    typedef logic [FIFO_CNT_BITS-1:0] fifo_cnt_t;
    typedef logic [LAT_CNT_BITS-1:0]  lat_cnt_t;

    ////////////////////////////////////////
    // Request bundles
    ////////////////////////////////////////
    typedef struct packed {
        baddr_t addr;   // Burst to fetch
    } rd_req_t;

    typedef struct packed {
        baddr_t addr;
        burst_t data;   // Four pixels to store
    } wr_req_t;

    typedef struct packed {
        logic   wr;     // 1 store, 0 fetch
        baddr_t addr;
        burst_t data;   // Don't care on a fetch
    } mem_req_t;

    // Scan order of the arbiter
    typedef enum logic [1:0] {PORT_RD0, PORT_RD1, PORT_WR0, PORT_WR1} port_t;

    typedef enum logic [1:0] {ARB_SCAN, ARB_ISSUE, ARB_WAIT} arb_state_t;

endpackage

// ==== verilog/wr_post_fifo.sv ====
`timescale 1ns/1ps

module wr_post_fifo (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  fbmem_pkg::wr_req_t in_req,
    output logic               out_valid,
    input  logic               out_ready,
    output fbmem_pkg::wr_req_t out_req
);
    import fbmem_pkg::*;

    wr_req_t   slots [WR_FIFO_DEPTH];  // Posted bursts
    fifo_ptr_t wr_ptr;                 // Next free slot
    fifo_ptr_t rd_ptr;                 // Oldest burst
    fifo_cnt_t count;                  // Occupancy
    fifo_cnt_t count_next;
    logic      push;
    logic      pop;

    // Pointer step with wrap, depth need not be a power of two
    function automatic fifo_ptr_t ptr_inc(input fifo_ptr_t p);
        if (p == fifo_ptr_t'(WR_FIFO_DEPTH - 1)) begin
            return '0;
        end
        return p + fifo_ptr_t'(1);
    endfunction

    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign out_valid = (count != '0);   // Visible one cycle after the push
    assign out_req   = slots[rd_ptr];   // Head of queue

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + fifo_cnt_t'(1);
        end else if (pop && !push) begin
            count_next = count - fifo_cnt_t'(1);
        end
    end

    ////////////////////////////////////////
    // Control state
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            in_ready <= 1'b0;              // Low until the first edge out of reset
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count    <= count_next;
            // Registered, but taken from the next count so it never lags
            in_ready <= (count_next != fifo_cnt_t'(WR_FIFO_DEPTH));
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= in_req;
        end
    end

endmodule

// ==== verilog/port_arbiter.sv ====
`timescale 1ns/1ps

module port_arbiter (
    input  logic                clk,
    input  logic                rst_n,

    // Read port 0
    input  logic                rd0_valid,
    output logic                rd0_ready,
    input  fbmem_pkg::rd_req_t  rd0_req,
    output logic                rd0_rsp_valid,
    output fbmem_pkg::burst_t   rd0_rsp_data,

    // Read port 1
    input  logic                rd1_valid,
    output logic                rd1_ready,
    input  fbmem_pkg::rd_req_t  rd1_req,
    output logic                rd1_rsp_valid,
    output fbmem_pkg::burst_t   rd1_rsp_data,

    // Write ports, fed by the posting FIFOs
    input  logic                wr0_valid,
    output logic                wr0_ready,
    input  fbmem_pkg::wr_req_t  wr0_req,
    input  logic                wr1_valid,
    output logic                wr1_ready,
    input  fbmem_pkg::wr_req_t  wr1_req,

    // Memory side
    output logic                mem_valid,
    input  logic                mem_ready,
    output fbmem_pkg::mem_req_t mem_req,
    input  logic                mem_done,
    input  fbmem_pkg::burst_t   mem_rdata,

    output logic                wr_active   // A write is granted and not yet done
);
    import fbmem_pkg::*;

    arb_state_t state;
    port_t      ptr;        // Port under the scanner
    mem_req_t   req_q;      // Captured request of the granted port
    logic       sel_valid;  // Valid of the port under the scanner
    mem_req_t   sel_req;    // Its request in memory form
    logic       issue;
    logic       rd_done;    // Completion of a granted read

    // Fixed rotation RD0, RD1, WR0, WR1
    function automatic port_t next_port(input port_t p);
        case (p)
            PORT_RD0: return PORT_RD1;
            PORT_RD1: return PORT_WR0;
            PORT_WR0: return PORT_WR1;
            default:  return PORT_RD0;
        endcase
    endfunction

    ////////////////////////////////////////
    // Request select
    ////////////////////////////////////////
    always_comb begin
        sel_valid = 1'b0;
        sel_req   = '0;
        case (ptr)
            PORT_RD0: begin
                sel_valid    = rd0_valid;
                sel_req.addr = rd0_req.addr;
            end
            PORT_RD1: begin
                sel_valid    = rd1_valid;
                sel_req.addr = rd1_req.addr;
            end
            PORT_WR0: begin
                sel_valid    = wr0_valid;
                sel_req.wr   = 1'b1;
                sel_req.addr = wr0_req.addr;
                sel_req.data = wr0_req.data;
            end
            default: begin
                sel_valid    = wr1_valid;
                sel_req.wr   = 1'b1;
                sel_req.addr = wr1_req.addr;
                sel_req.data = wr1_req.data;
            end
        endcase
    end

    // Ready only in the one ISSUE cycle of the granted port
    assign issue     = (state == ARB_ISSUE);
    assign rd0_ready = issue && (ptr == PORT_RD0);
    assign rd1_ready = issue && (ptr == PORT_RD1);
    assign wr0_ready = issue && (ptr == PORT_WR0);
    assign wr1_ready = issue && (ptr == PORT_WR1);

    assign mem_req = req_q;

    ////////////////////////////////////////
    // Completion routing
    ////////////////////////////////////////
    assign rd_done       = mem_done && (state == ARB_WAIT) && !req_q.wr;
    assign rd0_rsp_valid = rd_done && (ptr == PORT_RD0);  // Same cycle as mem_done
    assign rd1_rsp_valid = rd_done && (ptr == PORT_RD1);
    assign rd0_rsp_data  = rd0_rsp_valid ? mem_rdata : '0;  // Other port sees zero
    assign rd1_rsp_data  = rd1_rsp_valid ? mem_rdata : '0;

    // From grant through the done cycle of a write
    assign wr_active = (issue && sel_req.wr) || ((state == ARB_WAIT) && req_q.wr);

    ////////////////////////////////////////
    // Scanner FSM
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ARB_SCAN;
            ptr       <= PORT_RD0;
            mem_valid <= 1'b0;
        end else begin
            case (state)
                ARB_SCAN: begin
                    if (sel_valid) begin
                        state <= ARB_ISSUE;       // Stay on this port
                    end else begin
                        ptr <= next_port(ptr);    // Empty visit, one cycle
                    end
                end
                ARB_ISSUE: begin
                    mem_valid <= 1'b1;            // Request taken this cycle
                    state     <= ARB_WAIT;
                end
                ARB_WAIT: begin
                    if (mem_valid && mem_ready) begin
                        mem_valid <= 1'b0;        // Memory has it, now wait for done
                    end
                    if (mem_done) begin
                        state <= ARB_SCAN;
                        ptr   <= next_port(ptr);
                    end
                end
                default: state <= ARB_SCAN;
            endcase
        end
    end

    // Payload capture at grant
    always_ff @(posedge clk) begin
        if (issue) begin
            req_q <= sel_req;
        end
    end

endmodule

// ==== verilog/burst_mem.sv ====
`timescale 1ns/1ps

module burst_mem (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mem_valid,
    output logic                mem_ready,
    input  fbmem_pkg::mem_req_t mem_req,
    output logic                mem_done,
    output fbmem_pkg::burst_t   mem_rdata
);
    import fbmem_pkg::*;

    burst_t   mem_array [MEM_DEPTH];   // One burst per entry
    lat_cnt_t lat_cnt;                 // Cycles left of the access
    lat_cnt_t lat_next;
    mem_idx_t rd_idx;                  // Entry read out at done
    logic     accept;
    logic     last_cycle;              // Counter about to expire

    assign accept     = mem_valid && mem_ready;
    assign last_cycle = (lat_cnt == lat_cnt_t'(1));

    always_comb begin
        lat_next = lat_cnt;
        if (accept) begin
            lat_next = lat_cnt_t'(MEM_LATENCY);
        end else if (lat_cnt != '0) begin
            lat_next = lat_cnt - lat_cnt_t'(1);
        end
    end

    ////////////////////////////////////////
    // Access timer and array
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lat_cnt   <= '0;
            mem_ready <= 1'b0;
            mem_done  <= 1'b0;
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem_array[i] <= '0;       // Frame buffer starts black
            end
        end else begin
            lat_cnt   <= lat_next;
            mem_ready <= (lat_next == '0);   // Busy while the timer runs
            mem_done  <= last_cycle;         // MEM_LATENCY edges after accept
            if (accept && mem_req.wr) begin
                mem_array[mem_req.addr[MEM_ADDR_BITS-1:0]] <= mem_req.data;  // Store at accept
            end
        end
    end

    // Read path
    always_ff @(posedge clk) begin
        if (accept) begin
            rd_idx <= mem_req.addr[MEM_ADDR_BITS-1:0];
        end
        if (last_cycle) begin
            mem_rdata <= mem_array[rd_idx];  // Sampled when done rises
        end
    end

endmodule

// ==== verilog/fbmem_top.sv ====
`timescale 1ns/1ps

module fbmem_top (
    input  logic               clk,
    input  logic               rst_n,

    // Read clients
    input  logic               rd0_valid,
    output logic               rd0_ready,
    input  fbmem_pkg::rd_req_t rd0_req,
    output logic               rd0_rsp_valid,
    output fbmem_pkg::burst_t  rd0_rsp_data,
    input  logic               rd1_valid,
    output logic               rd1_ready,
    input  fbmem_pkg::rd_req_t rd1_req,
    output logic               rd1_rsp_valid,
    output fbmem_pkg::burst_t  rd1_rsp_data,

    // Write clients
    input  logic               wr0_valid,
    output logic               wr0_ready,
    input  fbmem_pkg::wr_req_t wr0_req,
    input  logic               wr1_valid,
    output logic               wr1_ready,
    input  fbmem_pkg::wr_req_t wr1_req,

    output logic               wr_pending   // Posted or in-flight writes remain
);
    import fbmem_pkg::*;

    // FIFO to arbiter
    logic     f0_valid;
    logic     f0_ready;
    wr_req_t  f0_req;
    logic     f1_valid;
    logic     f1_ready;
    wr_req_t  f1_req;

    // Arbiter to memory
    logic     mem_valid;
    logic     mem_ready;
    mem_req_t mem_req;
    logic     mem_done;
    burst_t   mem_rdata;
    logic     wr_active;

    ////////////////////////////////////////
    // Posting FIFOs
    ////////////////////////////////////////
    wr_post_fifo u_wr0_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (wr0_valid),
        .in_ready  (wr0_ready),
        .in_req    (wr0_req),
        .out_valid (f0_valid),
        .out_ready (f0_ready),
        .out_req   (f0_req)
    );

    wr_post_fifo u_wr1_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (wr1_valid),
        .in_ready  (wr1_ready),
        .in_req    (wr1_req),
        .out_valid (f1_valid),
        .out_ready (f1_ready),
        .out_req   (f1_req)
    );

    port_arbiter u_arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd0_valid     (rd0_valid),
        .rd0_ready     (rd0_ready),
        .rd0_req       (rd0_req),
        .rd0_rsp_valid (rd0_rsp_valid),
        .rd0_rsp_data  (rd0_rsp_data),
        .rd1_valid     (rd1_valid),
        .rd1_ready     (rd1_ready),
        .rd1_req       (rd1_req),
        .rd1_rsp_valid (rd1_rsp_valid),
        .rd1_rsp_data  (rd1_rsp_data),
        .wr0_valid     (f0_valid),
        .wr0_ready     (f0_ready),
        .wr0_req       (f0_req),
        .wr1_valid     (f1_valid),
        .wr1_ready     (f1_ready),
        .wr1_req       (f1_req),
        .mem_valid     (mem_valid),
        .mem_ready     (mem_ready),
        .mem_req       (mem_req),
        .mem_done      (mem_done),
        .mem_rdata     (mem_rdata),
        .wr_active     (wr_active)
    );

    // Stand-in for the SDRAM controller
    burst_mem u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_valid (mem_valid),
        .mem_ready (mem_ready),
        .mem_req   (mem_req),
        .mem_done  (mem_done),
        .mem_rdata (mem_rdata)
    );

    // No gap between FIFO pop and arbiter grant, wr_active covers the hand-over
    assign wr_pending = f0_valid || f1_valid || wr_active;

endmodule

// ==== tb/fbmem_properties.sv ====
`timescale 1ns/1ps

module fbmem_properties (
    input logic                clk,
    input logic                rst_n,
    input logic                rd0_rsp_valid,
    input logic                rd1_rsp_valid,
    input logic                mem_valid,
    input logic                mem_ready,
    input fbmem_pkg::mem_req_t mem_req,
    input logic                mem_done
);

    logic outstanding;   // Accepted by the memory, done not yet seen

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= 1'b0;
        end else if (mem_valid && mem_ready) begin
            outstanding <= 1'b1;
        end else if (mem_done) begin
            outstanding <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // Routing and handshakes
    ////////////////////////////////////////
    a_one_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd0_rsp_valid && rd1_rsp_valid))
        else $error("Both read ports got a response in one cycle");

    a_single_xfer: assert property (@(posedge clk) disable iff (!rst_n)
        mem_valid |-> !outstanding)
        else $error("New memory request while a transfer is outstanding");

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_valid && !mem_ready) |=> (mem_valid && $stable(mem_req)))
        else $error("Memory request dropped or changed before mem_ready");

endmodule

bind port_arbiter fbmem_properties u_props (
    .clk           (clk),
    .rst_n         (rst_n),
    .rd0_rsp_valid (rd0_rsp_valid),
    .rd1_rsp_valid (rd1_rsp_valid),
    .mem_valid     (mem_valid),
    .mem_ready     (mem_ready),
    .mem_req       (mem_req),
    .mem_done      (mem_done)
);

// ==== tb/tb_fbmem.sv ====
`timescale 1ns/1ps

module tb_fbmem;
    import fbmem_pkg::*;

    localparam int          CLK_HALF     = 20;                       // 40 ns period
    localparam int          RESET_CYCLES = 8;
    localparam int          N_XFERS      = 99;                       // Memory transfers, all tests
    localparam int          ROUND_CYCLES = 4 * (MEM_LATENCY + 4);    // Worst case full scan round
    localparam int          TIMEOUT_CYC  = N_XFERS * ROUND_CYCLES + RESET_CYCLES + 400;
    localparam int unsigned SEED         = 32'hd2a15cac;

    logic    clk;
    logic    rst_n;
    logic    rd_valid [2];
    logic    rd_ready [2];
    rd_req_t rd_req [2];
    logic    rd_rsp_valid [2];
    burst_t  rd_rsp_data [2];
    logic    wr_valid [2];
    logic    wr_ready [2];
    wr_req_t wr_req [2];
    logic    wr_pending;

    burst_t  ref_mem [mem_idx_t];  // Expected frame buffer, missing entry reads as zero
    burst_t  exp_q [2][$];         // Expected responses per read port
    baddr_t  t5_addrs [$];         // Written during the random mix
    string   test_name;
    int      flag_checks;
    int      flag_errors;
    int      burst_checks;         // Owned by the response checker
    int      burst_errors;
    int      rsp_seq;
    int      rsp_cnt [2];
    int      rsp_order [2];        // Sequence number of the latest response
    int      full_cycles;          // wr0 held off by a full FIFO

    fbmem_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd0_valid     (rd_valid[0]),
        .rd0_ready     (rd_ready[0]),
        .rd0_req       (rd_req[0]),
        .rd0_rsp_valid (rd_rsp_valid[0]),
        .rd0_rsp_data  (rd_rsp_data[0]),
        .rd1_valid     (rd_valid[1]),
        .rd1_ready     (rd_ready[1]),
        .rd1_req       (rd_req[1]),
        .rd1_rsp_valid (rd_rsp_valid[1]),
        .rd1_rsp_data  (rd_rsp_data[1]),
        .wr0_valid     (wr_valid[0]),
        .wr0_ready     (wr_ready[0]),
        .wr0_req       (wr_req[0]),
        .wr1_valid     (wr_valid[1]),
        .wr1_ready     (wr_ready[1]),
        .wr1_req       (wr_req[1]),
        .wr_pending    (wr_pending)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Hard stop if a handshake never completes
    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("Error: run did not finish within %0d cycles, a handshake hung", TIMEOUT_CYC);
        $display("Something failed");
        $finish;
    end

    ////////////////////////////////////////
    // Reference model and compares
    ////////////////////////////////////////
    function automatic burst_t expected_burst(input baddr_t addr);
        mem_idx_t idx;
        idx = addr[MEM_ADDR_BITS-1:0];      // Memory decodes low bits only
        if (ref_mem.exists(idx)) begin
            return ref_mem[idx];
        end
        return '0;                          // Cleared at reset
    endfunction

    function automatic burst_t rand_burst();
        burst_t b;
        for (int i = 0; i < BURST_LEN; i++) begin
            b[i] = pix_t'($urandom);
        end
        return b;
    endfunction

    task automatic check_burst(input string what, input burst_t exp, input burst_t act);
        burst_checks++;
        if (act !== exp) begin
            burst_errors++;
            $display("Fail %s: %s expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        flag_checks++;
        if (act !== exp) begin
            flag_errors++;
            $display("Fail %s: %s expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    // Response checker, outputs settle well before the falling edge
    initial begin
        forever begin
            @(negedge clk);
            if (rst_n) begin
                for (int p = 0; p < 2; p++) begin
                    if (rd_rsp_valid[p]) begin
                        rsp_seq++;
                        rsp_cnt[p]++;
                        rsp_order[p] = rsp_seq;
                        if (exp_q[p].size() == 0) begin
                            burst_errors++;
                            $display("Error: read port %0d responded with no request open", p);
                        end else begin
                            check_burst($sformatf("rd%0d_rsp_data", p), exp_q[p].pop_front(),
                                        rd_rsp_data[p]);
                        end
                    end
                end
                if (wr_valid[0] && !wr_ready[0]) begin
                    full_cycles++;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Client drivers
    ////////////////////////////////////////
    // Called and returning 2 ns after a rising edge
    task automatic do_read(input int p, input baddr_t addr);
        rd_req[p].addr = addr;
        rd_valid[p]    = 1'b1;
        do @(negedge clk); while (!rd_ready[p]);
        exp_q[p].push_back(expected_burst(addr));   // Taken on the coming edge
        @(posedge clk);
        #2;
        rd_valid[p] = 1'b0;
    endtask

    task automatic do_write(input int p, input baddr_t addr, input burst_t data);
        wr_req[p].addr = addr;
        wr_req[p].data = data;
        wr_valid[p]    = 1'b1;
        do @(negedge clk); while (!wr_ready[p]);
        ref_mem[addr[MEM_ADDR_BITS-1:0]] = data;    // Posted into the FIFO
        @(posedge clk);
        #2;
        wr_valid[p] = 1'b0;
    endtask

    task automatic wait_responses();
        while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic wait_drained();
        do @(negedge clk); while (wr_pending);
        @(posedge clk);
        #2;
    endtask

    // Reads stay in the low half of the decoded range
    task automatic random_reads(input int p, input int n);
        baddr_t addr;
        for (int i = 0; i < n; i++) begin
            addr = baddr_t'($urandom);
            addr[MEM_ADDR_BITS-1:0] = mem_idx_t'($urandom_range(0, 127));
            do_read(p, addr);
            repeat ($urandom_range(0, 3)) begin
                @(posedge clk);
                #2;
            end
        end
    endtask

    // Upper half, one quarter per write port, so store order per entry is FIFO order
    task automatic random_writes(input int p, input int n);
        baddr_t addr;
        for (int i = 0; i < n; i++) begin
            addr = baddr_t'($urandom);
            addr[MEM_ADDR_BITS-1:0] = mem_idx_t'(128 + 64 * p + $urandom_range(0, 63));
            t5_addrs.push_back(addr);
            do_write(p, addr, rand_burst());
            repeat ($urandom_range(0, 3)) begin
                @(posedge clk);
                #2;
            end
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial begin
        int base0;
        int base1;
        int base_full;
        void'($urandom(SEED));
        rst_n = 1'b0;
        for (int p = 0; p < 2; p++) begin
            rd_valid[p] = 1'b0;
            rd_req[p]   = '0;
            wr_valid[p] = 1'b0;
            wr_req[p]   = '0;
        end

        test_name = "reset_state";
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        for (int p = 0; p < 2; p++) begin
            check_flag($sformatf("rd%0d_ready", p), 1'b0, rd_ready[p]);
            check_flag($sformatf("wr%0d_ready", p), 1'b0, wr_ready[p]);
            check_flag($sformatf("rd%0d_rsp_valid", p), 1'b0, rd_rsp_valid[p]);
        end
        check_flag("wr_pending", 1'b0, wr_pending);
        @(posedge clk);
        #2;
        rst_n = 1'b1;
        do_read(0, baddr_t'($urandom));   // Fresh memory reads zero
        do_read(1, baddr_t'($urandom));
        wait_responses();

        test_name = "write_read";
        do_write(0, 24'h3a5c21, rand_burst());
        do_write(1, 24'h071e42, rand_burst());
        wait_drained();
        do_read(0, 24'h3a5c21);
        do_read(1, 24'h071e42);
        do_read(0, 24'h071e42);
        do_read(1, 24'h3a5c21);
        wait_responses();

        // Done on RD0 parks the scanner at RD1, it has left RD1 one edge later
        test_name = "dual_read";
        do_read(0, 24'h003333);
        do @(negedge clk); while (!rd_rsp_valid[0]);
        @(posedge clk);
        @(posedge clk);
        #2;
        base0 = rsp_cnt[0];
        base1 = rsp_cnt[1];
        fork
            do_read(0, 24'h071e42);
            do_read(1, 24'h3a5c21);
        join
        wait_responses();
        check_flag("one response on rd0", 1'b1, (rsp_cnt[0] - base0) == 1);
        check_flag("one response on rd1", 1'b1, (rsp_cnt[1] - base1) == 1);
        check_flag("rd0 answered before rd1", 1'b1, rsp_order[0] < rsp_order[1]);

        test_name = "fifo_full";
        base_full = full_cycles;
        for (int i = 0; i < 2 * WR_FIFO_DEPTH; i++) begin
            do_write(0, {16'hb0b0, 8'(8'h10 + i)}, rand_burst());   // Back to back
        end
        wait_drained();
        check_flag("wr0_ready low while full", 1'b1, full_cycles > base_full);
        for (int i = 0; i < 2 * WR_FIFO_DEPTH; i++) begin
            do_read(i % 2, {16'hb0b0, 8'(8'h10 + i)});
        end
        wait_responses();

        test_name = "random_mix";
        fork
            random_reads(0, 12);
            random_reads(1, 12);
            random_writes(0, 12);
            random_writes(1, 12);
        join
        wait_drained();
        wait_responses();
        foreach (t5_addrs[i]) begin
            do_read(i % 2, t5_addrs[i]);   // Read back what was posted
        end
        wait_responses();

        $display("Flag checks %0d, errors %0d, burst checks %0d, errors %0d",
                 flag_checks, flag_errors, burst_checks, burst_errors);
        if (flag_errors + burst_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
verilog/fbmem_pkg.sv
verilog/wr_post_fifo.sv
verilog/port_arbiter.sv
verilog/burst_mem.sv
verilog/fbmem_top.sv
tb/fbmem_properties.sv
tb/tb_fbmem.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the frame-buffer port multiplexer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_fbmem -f tb.f -o sim_fbmem \
    && ./obj_dir/sim_fbmem 2>&1 | tee sim.log \
    || echo "run.sh: build or simulation did not complete"

# Verdict comes from the simulation log
grep -qx 'Everything OK' sim.log 2>/dev/null \
    && echo "run.sh: PASS" \
    || { echo "run.sh: FAIL"; exit 1; }
